//--- i3c_csr_pkg.sv
// I3C CSR front end shared definitions
// Bus widths, register map, reset values, response codes and adapter states
`default_nettype none

package i3c_csr_pkg;

  localparam int unsigned AXI_ADDR_W  = 12;
  localparam int unsigned AXI_ID_W    = 2;
  localparam int unsigned AXI_USER_W  = 32;
  localparam int unsigned CSR_ADDR_W  = 5;
  localparam int unsigned CSR_DATA_W  = 32;
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = 2;

  typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
  typedef logic [AXI_ID_W-1:0]    axi_id_t;
  typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;
  typedef logic [CSR_DATA_W-1:0]  csr_data_t;
  typedef logic [1:0]             axi_resp_t;
  typedef logic [2:0]             queue_level_t;
  typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // Only single-beat INCR word transfers are legal
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;

  localparam csr_addr_t REG_HC_VERSION   = 5'h00;
  localparam csr_addr_t REG_HC_CONTROL   = 5'h04;
  localparam csr_addr_t REG_SCRATCH      = 5'h08;
  localparam csr_addr_t REG_QUEUE_STATUS = 5'h0C;
  localparam csr_addr_t REG_DATA_PORT    = 5'h10;

  localparam csr_data_t VERSION_VALUE    = 32'h0000_0120;
  localparam csr_data_t HC_CONTROL_MASK  = 32'h8000_00FF;
  localparam csr_data_t HC_CONTROL_RESET = 32'h0000_0000;
  localparam csr_data_t SCRATCH_RESET    = 32'h0000_0000;

  // Queue status bit positions with the level in [2:0]
  localparam int unsigned QSTAT_EMPTY_BIT = 8;
  localparam int unsigned QSTAT_FULL_BIT  = 9;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_ACK,
    ST_RRESP,
    ST_BRESP
  } adapter_state_e;

endpackage

`default_nettype wire

//--- csr_data_queue.sv
// Small circular buffer behind the data port register
// Push and pop are strobes and the caller guards against full and empty
`timescale 1ns/1ps
`default_nettype none

module csr_data_queue
  import i3c_csr_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_i,
  input  wire            push_i,
  input  wire csr_data_t push_data_i,
  input  wire            pop_i,
  output csr_data_t      head_data_o,
  output queue_level_t   level_o,
  output logic           empty_o,
  output logic           full_o
);

  csr_data_t    mem_q [QUEUE_DEPTH];
  queue_ptr_t   wr_ptr_q;
  queue_ptr_t   rd_ptr_q;
  queue_level_t level_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level alone
      case ({push_i, pop_i})
        2'b10: level_q <= level_q + 1'b1;
        2'b01: level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign head_data_o = mem_q[rd_ptr_q];
  assign level_o     = level_q;
  assign empty_o     = (level_q == '0);
  assign full_o      = (level_q == queue_level_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- csr_regfile.sv
// I3C controller CSR block on the CPU-interface bus
// Answers every request one cycle later with ack, data and error
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
  import i3c_csr_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_i,
  input  wire            cpuif_req_i,
  input  wire            cpuif_req_is_wr_i,
  input  wire csr_addr_t cpuif_addr_i,
  input  wire csr_data_t cpuif_wr_data_i,
  input  wire csr_data_t cpuif_wr_biten_i,
  output logic           cpuif_rd_ack_o,
  output logic           cpuif_rd_err_o,
  output csr_data_t      cpuif_rd_data_o,
  output logic           cpuif_wr_ack_o,
  output logic           cpuif_wr_err_o
);

  csr_data_t    hc_control_q;
  csr_data_t    scratch_q;

  logic         rd_req;
  logic         wr_req;
  logic         sel_version;
  logic         sel_control;
  logic         sel_scratch;
  logic         sel_status;
  logic         sel_data;
  logic         sel_none;

  logic         push;
  logic         pop;
  csr_data_t    head_data;
  queue_level_t level;
  logic         empty;
  logic         full;

  csr_data_t    queue_status;
  csr_data_t    ctrl_wr_en;
  csr_data_t    rd_mux;
  logic         rd_err;
  logic         wr_err;

  assign rd_req = cpuif_req_i && !cpuif_req_is_wr_i;
  assign wr_req = cpuif_req_i && cpuif_req_is_wr_i;

  // Offsets are word aligned, so exact compare also rejects unaligned access
  assign sel_version = (cpuif_addr_i == REG_HC_VERSION);
  assign sel_control = (cpuif_addr_i == REG_HC_CONTROL);
  assign sel_scratch = (cpuif_addr_i == REG_SCRATCH);
  assign sel_status  = (cpuif_addr_i == REG_QUEUE_STATUS);
  assign sel_data    = (cpuif_addr_i == REG_DATA_PORT);
  assign sel_none    = !(sel_version || sel_control || sel_scratch ||
                         sel_status || sel_data);

  assign push = wr_req && sel_data && !full;
  assign pop  = rd_req && sel_data && !empty;

  assign rd_err = sel_none || (sel_data && empty);
  assign wr_err = sel_none || (sel_data && full);

  assign ctrl_wr_en = cpuif_wr_biten_i & HC_CONTROL_MASK;

  always_comb begin
    queue_status                  = '0;
    queue_status[2:0]             = level;
    queue_status[QSTAT_EMPTY_BIT] = empty;
    queue_status[QSTAT_FULL_BIT]  = full;
  end

  always_comb begin
    rd_mux = '0;
    if (sel_version) begin
      rd_mux = VERSION_VALUE;
    end else if (sel_control) begin
      rd_mux = hc_control_q;
    end else if (sel_scratch) begin
      rd_mux = scratch_q;
    end else if (sel_status) begin
      rd_mux = queue_status;
    end else if (sel_data && !empty) begin
      rd_mux = head_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cpuif_rd_ack_o <= 1'b0;
      cpuif_rd_err_o <= 1'b0;
      cpuif_wr_ack_o <= 1'b0;
      cpuif_wr_err_o <= 1'b0;
      hc_control_q   <= HC_CONTROL_RESET;
      scratch_q      <= SCRATCH_RESET;
    end else begin
      cpuif_rd_ack_o <= rd_req;
      cpuif_rd_err_o <= rd_req && rd_err;
      cpuif_wr_ack_o <= wr_req;
      cpuif_wr_err_o <= wr_req && wr_err;
      if (wr_req && sel_control) begin
        hc_control_q <= (hc_control_q & ~ctrl_wr_en) | (cpuif_wr_data_i & ctrl_wr_en);
      end
      if (wr_req && sel_scratch) begin
        scratch_q <= (scratch_q & ~cpuif_wr_biten_i) |
                     (cpuif_wr_data_i & cpuif_wr_biten_i);
      end
    end
  end

  // Read data is only meaningful alongside the ack
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      cpuif_rd_data_o <= rd_mux;
    end
  end

  csr_data_queue i_data_queue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_data_i (cpuif_wr_data_i),
    .pop_i       (pop),
    .head_data_o (head_data),
    .level_o     (level),
    .empty_o     (empty),
    .full_o      (full)
  );

endmodule

`default_nettype wire

//--- axi_adapter.sv
// AXI4 single-beat slave that drives the CPU-interface register bus
// Illegal bursts, sizes, lengths and locked accesses get SLVERR without a bus access
`timescale 1ns/1ps
`default_nettype none

module axi_adapter
  import i3c_csr_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_i,

  // AXI read address and data
  input  wire axi_addr_t       araddr_i,
  input  wire [1:0]            arburst_i,
  input  wire [2:0]            arsize_i,
  input  wire [7:0]            arlen_i,
  input  wire [AXI_USER_W-1:0] aruser_i,
  input  wire axi_id_t         arid_i,
  input  wire                  arlock_i,
  input  wire                  arvalid_i,
  output logic                 arready_o,

  output csr_data_t            rdata_o,
  output axi_resp_t            rresp_o,
  output axi_id_t              rid_o,
  output logic                 rlast_o,
  output logic                 rvalid_o,
  input  wire                  rready_i,

  // AXI write address, data and response
  input  wire axi_addr_t       awaddr_i,
  input  wire [1:0]            awburst_i,
  input  wire [2:0]            awsize_i,
  input  wire [7:0]            awlen_i,
  input  wire [AXI_USER_W-1:0] awuser_i,
  input  wire axi_id_t         awid_i,
  input  wire                  awlock_i,
  input  wire                  awvalid_i,
  output logic                 awready_o,

  input  wire csr_data_t       wdata_i,
  input  wire [3:0]            wstrb_i,
  input  wire                  wlast_i,
  input  wire                  wvalid_i,
  output logic                 wready_o,

  output axi_resp_t            bresp_o,
  output axi_id_t              bid_o,
  output logic                 bvalid_o,
  input  wire                  bready_i,

  // CPU-interface bus
  output logic                 cpuif_req_o,
  output logic                 cpuif_req_is_wr_o,
  output csr_addr_t            cpuif_addr_o,
  output csr_data_t            cpuif_wr_data_o,
  output csr_data_t            cpuif_wr_biten_o,
  input  wire                  cpuif_rd_ack_i,
  input  wire                  cpuif_rd_err_i,
  input  wire csr_data_t       cpuif_rd_data_i,
  input  wire                  cpuif_wr_ack_i,
  input  wire                  cpuif_wr_err_i
);

  adapter_state_e state_q;
  logic           ar_held_q;
  logic           aw_held_q;
  logic           w_held_q;
  logic           cur_wr_q;

  csr_addr_t      ar_addr_q;
  csr_addr_t      aw_addr_q;
  axi_id_t        ar_id_q;
  axi_id_t        aw_id_q;
  logic           ar_ok_q;
  logic           aw_ok_q;
  logic           w_last_q;
  csr_data_t      w_data_q;
  logic [3:0]     w_strb_q;
  csr_data_t      rdata_q;
  axi_resp_t      rresp_q;
  axi_resp_t      bresp_q;

  logic           ar_take;
  logic           aw_take;
  logic           w_take;
  logic           ar_legal;
  logic           aw_legal;
  logic           rd_pend;
  logic           wr_pend;
  logic           rd_ok;
  logic           wr_ok;

  assign arready_o = (state_q == ST_IDLE) && !ar_held_q;
  assign awready_o = (state_q == ST_IDLE) && !aw_held_q;
  assign wready_o  = (state_q == ST_IDLE) && !w_held_q;

  assign ar_take = arvalid_i && arready_o;
  assign aw_take = awvalid_i && awready_o;
  assign w_take  = wvalid_i && wready_o;

  assign ar_legal = (arlen_i == 8'd0) && (arburst_i == AXI_BURST_INCR) &&
                    (arsize_i == AXI_SIZE_WORD) && !arlock_i;
  assign aw_legal = (awlen_i == 8'd0) && (awburst_i == AXI_BURST_INCR) &&
                    (awsize_i == AXI_SIZE_WORD) && !awlock_i;

  // Look through to this cycle's handshake so a request leaves IDLE at capture
  assign rd_pend = ar_held_q || ar_take;
  assign wr_pend = (aw_held_q || aw_take) && (w_held_q || w_take);
  assign rd_ok   = ar_take ? ar_legal : ar_ok_q;
  assign wr_ok   = (aw_take ? aw_legal : aw_ok_q) && (w_take ? wlast_i : w_last_q);

  always_ff @(posedge clk_i) begin
    if (ar_take) begin
      ar_addr_q <= araddr_i[CSR_ADDR_W-1:0];
      ar_id_q   <= arid_i;
      ar_ok_q   <= ar_legal;
    end
    if (aw_take) begin
      aw_addr_q <= awaddr_i[CSR_ADDR_W-1:0];
      aw_id_q   <= awid_i;
      aw_ok_q   <= aw_legal;
    end
    if (w_take) begin
      w_data_q <= wdata_i;
      w_strb_q <= wstrb_i;
      w_last_q <= wlast_i;
    end
  end

  // Preload an error response while idle and let a legal access overwrite it on ack
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      rdata_q <= '0;
      rresp_q <= RESP_SLVERR;
      bresp_q <= RESP_SLVERR;
    end else if (state_q == ST_WAIT_ACK) begin
      if (cpuif_rd_ack_i) begin
        rdata_q <= cpuif_rd_data_i;
        rresp_q <= cpuif_rd_err_i ? RESP_SLVERR : RESP_OKAY;
      end
      if (cpuif_wr_ack_i) begin
        bresp_q <= cpuif_wr_err_i ? RESP_SLVERR : RESP_OKAY;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      ar_held_q <= 1'b0;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      cur_wr_q  <= 1'b0;
    end else begin
      if (ar_take) ar_held_q <= 1'b1;
      if (aw_take) aw_held_q <= 1'b1;
      if (w_take) w_held_q <= 1'b1;

      case (state_q)
        ST_IDLE: begin
          // A complete write goes ahead of a pending read
          if (wr_pend) begin
            cur_wr_q <= 1'b1;
            state_q  <= wr_ok ? ST_REQ : ST_BRESP;
          end else if (rd_pend) begin
            cur_wr_q <= 1'b0;
            state_q  <= rd_ok ? ST_REQ : ST_RRESP;
          end
        end
        ST_REQ: begin
          state_q <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (cur_wr_q && cpuif_wr_ack_i) begin
            state_q <= ST_BRESP;
          end else if (!cur_wr_q && cpuif_rd_ack_i) begin
            state_q <= ST_RRESP;
          end
        end
        ST_RRESP: begin
          if (rready_i) begin
            state_q   <= ST_IDLE;
            ar_held_q <= 1'b0;
          end
        end
        ST_BRESP: begin
          if (bready_i) begin
            state_q   <= ST_IDLE;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign cpuif_req_o       = (state_q == ST_REQ);
  assign cpuif_req_is_wr_o = cur_wr_q;
  assign cpuif_addr_o      = cur_wr_q ? aw_addr_q : ar_addr_q;
  assign cpuif_wr_data_o   = w_data_q;

  // One strobe bit covers a byte lane
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      cpuif_wr_biten_o[8*b +: 8] = {8{w_strb_q[b]}};
    end
  end

  assign rvalid_o = (state_q == ST_RRESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;
  assign rid_o    = ar_id_q;
  assign rlast_o  = rvalid_o;

  assign bvalid_o = (state_q == ST_BRESP);
  assign bresp_o  = bresp_q;
  assign bid_o    = aw_id_q;

endmodule

`default_nettype wire

//--- i3c_csr_axi_top.sv
// AXI4 front end for the I3C controller CSR block
`timescale 1ns/1ps
`default_nettype none

module i3c_csr_axi_top
  import i3c_csr_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_i,

  input  wire axi_addr_t       araddr_i,
  input  wire [1:0]            arburst_i,
  input  wire [2:0]            arsize_i,
  input  wire [7:0]            arlen_i,
  input  wire [AXI_USER_W-1:0] aruser_i,
  input  wire axi_id_t         arid_i,
  input  wire                  arlock_i,
  input  wire                  arvalid_i,
  output logic                 arready_o,

  output csr_data_t            rdata_o,
  output axi_resp_t            rresp_o,
  output axi_id_t              rid_o,
  output logic                 rlast_o,
  output logic                 rvalid_o,
  input  wire                  rready_i,

  input  wire axi_addr_t       awaddr_i,
  input  wire [1:0]            awburst_i,
  input  wire [2:0]            awsize_i,
  input  wire [7:0]            awlen_i,
  input  wire [AXI_USER_W-1:0] awuser_i,
  input  wire axi_id_t         awid_i,
  input  wire                  awlock_i,
  input  wire                  awvalid_i,
  output logic                 awready_o,

  input  wire csr_data_t       wdata_i,
  input  wire [3:0]            wstrb_i,
  input  wire                  wlast_i,
  input  wire                  wvalid_i,
  output logic                 wready_o,

  output axi_resp_t            bresp_o,
  output axi_id_t              bid_o,
  output logic                 bvalid_o,
  input  wire                  bready_i
);

  logic      cpuif_req;
  logic      cpuif_req_is_wr;
  csr_addr_t cpuif_addr;
  csr_data_t cpuif_wr_data;
  csr_data_t cpuif_wr_biten;
  logic      cpuif_rd_ack;
  logic      cpuif_rd_err;
  csr_data_t cpuif_rd_data;
  logic      cpuif_wr_ack;
  logic      cpuif_wr_err;

  axi_adapter i_axi_adapter (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .araddr_i          (araddr_i),
    .arburst_i         (arburst_i),
    .arsize_i          (arsize_i),
    .arlen_i           (arlen_i),
    .aruser_i          (aruser_i),
    .arid_i            (arid_i),
    .arlock_i          (arlock_i),
    .arvalid_i         (arvalid_i),
    .arready_o         (arready_o),
    .rdata_o           (rdata_o),
    .rresp_o           (rresp_o),
    .rid_o             (rid_o),
    .rlast_o           (rlast_o),
    .rvalid_o          (rvalid_o),
    .rready_i          (rready_i),
    .awaddr_i          (awaddr_i),
    .awburst_i         (awburst_i),
    .awsize_i          (awsize_i),
    .awlen_i           (awlen_i),
    .awuser_i          (awuser_i),
    .awid_i            (awid_i),
    .awlock_i          (awlock_i),
    .awvalid_i         (awvalid_i),
    .awready_o         (awready_o),
    .wdata_i           (wdata_i),
    .wstrb_i           (wstrb_i),
    .wlast_i           (wlast_i),
    .wvalid_i          (wvalid_i),
    .wready_o          (wready_o),
    .bresp_o           (bresp_o),
    .bid_o             (bid_o),
    .bvalid_o          (bvalid_o),
    .bready_i          (bready_i),
    .cpuif_req_o       (cpuif_req),
    .cpuif_req_is_wr_o (cpuif_req_is_wr),
    .cpuif_addr_o      (cpuif_addr),
    .cpuif_wr_data_o   (cpuif_wr_data),
    .cpuif_wr_biten_o  (cpuif_wr_biten),
    .cpuif_rd_ack_i    (cpuif_rd_ack),
    .cpuif_rd_err_i    (cpuif_rd_err),
    .cpuif_rd_data_i   (cpuif_rd_data),
    .cpuif_wr_ack_i    (cpuif_wr_ack),
    .cpuif_wr_err_i    (cpuif_wr_err)
  );

  csr_regfile i_csr_regfile (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .cpuif_req_i       (cpuif_req),
    .cpuif_req_is_wr_i (cpuif_req_is_wr),
    .cpuif_addr_i      (cpuif_addr),
    .cpuif_wr_data_i   (cpuif_wr_data),
    .cpuif_wr_biten_i  (cpuif_wr_biten),
    .cpuif_rd_ack_o    (cpuif_rd_ack),
    .cpuif_rd_err_o    (cpuif_rd_err),
    .cpuif_rd_data_o   (cpuif_rd_data),
    .cpuif_wr_ack_o    (cpuif_wr_ack),
    .cpuif_wr_err_o    (cpuif_wr_err)
  );

endmodule

`default_nettype wire

//--- i3c_csr_axi_checker.sv
// AXI handshake assertions for the CSR adapter
// Bound into every axi_adapter instance
`timescale 1ns/1ps
`default_nettype none

module i3c_csr_axi_checker
  import i3c_csr_pkg::*;
(
  input wire            clk_i,
  input wire            rst_i,
  input wire            rvalid_i,
  input wire            rready_i,
  input wire csr_data_t rdata_i,
  input wire axi_resp_t rresp_i,
  input wire            bvalid_i,
  input wire            bready_i,
  input wire axi_resp_t bresp_i,
  input wire            req_i,
  input wire            rd_ack_i,
  input wire            wr_ack_i
);

  // Response channels hold until the master takes them
  r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else $error("R channel dropped or changed before rready");

  b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("B channel dropped or changed before bready");

  // The regfile acks on the very next cycle
  req_single: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |=> !req_i && (rd_ack_i || wr_ack_i))
    else $error("Register request not followed by its ack");

  rb_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rvalid_i && bvalid_i))
    else $error("rvalid and bvalid high together");

endmodule

bind axi_adapter i3c_csr_axi_checker i_axi_checker (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i),
  .rdata_i  (rdata_o),
  .rresp_i  (rresp_o),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .bresp_i  (bresp_o),
  .req_i    (cpuif_req_o),
  .rd_ack_i (cpuif_rd_ack_i),
  .wr_ack_i (cpuif_wr_ack_i)
);

`default_nettype wire

//--- i3c_csr_axi_tb.sv
// Testbench for the AXI4 front end of the I3C CSR block
// Applies a table of single-beat reads and writes with random response back-pressure
`timescale 1ns/1ps
`default_nettype none

module i3c_csr_axi_tb
  import i3c_csr_pkg::*;
;

  typedef struct {
    string      name;
    logic       is_wr;
    axi_addr_t  addr;
    csr_data_t  data;
    logic [3:0] strb;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    csr_data_t  exp_data;
    axi_resp_t  exp_resp;
  } test_t;

  logic clk_i;
  logic rst_i;
  axi_addr_t araddr_i;
  logic [1:0] arburst_i;
  logic [2:0] arsize_i;
  logic [7:0] arlen_i;
  logic [AXI_USER_W-1:0] aruser_i;
  axi_id_t arid_i;
  logic arlock_i;
  logic arvalid_i;
  logic arready_o;
  csr_data_t rdata_o;
  axi_resp_t rresp_o;
  axi_id_t rid_o;
  logic rlast_o;
  logic rvalid_o;
  logic rready_i;
  axi_addr_t awaddr_i;
  logic [1:0] awburst_i;
  logic [2:0] awsize_i;
  logic [7:0] awlen_i;
  logic [AXI_USER_W-1:0] awuser_i;
  axi_id_t awid_i;
  logic awlock_i;
  logic awvalid_i;
  logic awready_o;
  csr_data_t wdata_i;
  logic [3:0] wstrb_i;
  logic wlast_i;
  logic wvalid_i;
  logic wready_o;
  axi_resp_t bresp_o;
  axi_id_t bid_o;
  logic bvalid_o;
  logic bready_i;

  test_t  tests[$];
  integer seed;
  int     cycle_count = 0;
  int     cycle_limit = 0;

  i3c_csr_axi_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the DUT stopped answering after %0d cycles", cycle_count);
      $display(">>> FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_test(input string name, input logic is_wr, input axi_addr_t addr,
                          input csr_data_t data, input logic [3:0] strb,
                          input csr_data_t exp_data, input axi_resp_t exp_resp);
    test_t t;
    t.name     = name;
    t.is_wr    = is_wr;
    t.addr     = addr;
    t.data     = data;
    t.strb     = strb;
    t.len      = 8'd0;
    t.size     = 3'd2;
    t.burst    = 2'b01;
    t.lock     = 1'b0;
    t.exp_data = exp_data;
    t.exp_resp = exp_resp;
    tests.push_back(t);
  endtask

  // Requests with illegal AXI attributes always end in SLVERR with zero data
  task automatic add_bad(input string name, input logic is_wr, input axi_addr_t addr,
                         input logic [7:0] len, input logic [2:0] size,
                         input logic [1:0] burst, input logic lock);
    test_t t;
    t.name     = name;
    t.is_wr    = is_wr;
    t.addr     = addr;
    t.data     = 32'hFFFF_FFFF;
    t.strb     = 4'hF;
    t.len      = len;
    t.size     = size;
    t.burst    = burst;
    t.lock     = lock;
    t.exp_data = 32'h0;
    t.exp_resp = RESP_SLVERR;
    tests.push_back(t);
  endtask

  task automatic build_table();
    add_test("rst_version", 1'b0, 12'h000, 32'h0, 4'h0, 32'h0000_0120, RESP_OKAY);
    add_test("rst_control", 1'b0, 12'h004, 32'h0, 4'h0, 32'h0000_0000, RESP_OKAY);
    add_test("rst_scratch", 1'b0, 12'h008, 32'h0, 4'h0, 32'h0000_0000, RESP_OKAY);
    add_test("rst_status", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0100, RESP_OKAY);
    add_test("wr_scratch_full", 1'b1, 12'h008, 32'h1234_5678, 4'hF, 32'h0, RESP_OKAY);
    add_test("rd_scratch_full", 1'b0, 12'h008, 32'h0, 4'h0, 32'h1234_5678, RESP_OKAY);
    add_test("wr_scratch_part", 1'b1, 12'h008, 32'hAABB_CCDD, 4'b0101, 32'h0, RESP_OKAY);
    add_test("rd_scratch_part", 1'b0, 12'h008, 32'h0, 4'h0, 32'h12BB_56DD, RESP_OKAY);
    add_test("wr_control_mask", 1'b1, 12'h004, 32'hDEAD_BEEF, 4'hF, 32'h0, RESP_OKAY);
    add_test("rd_control_mask", 1'b0, 12'h004, 32'h0, 4'h0, 32'h8000_00EF, RESP_OKAY);
    add_test("wr_control_b0", 1'b1, 12'h004, 32'h0000_0000, 4'b0001, 32'h0, RESP_OKAY);
    add_test("rd_control_b0", 1'b0, 12'h004, 32'h0, 4'h0, 32'h8000_0000, RESP_OKAY);
    add_test("wr_version_ro", 1'b1, 12'h000, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_OKAY);
    add_test("rd_version_ro", 1'b0, 12'h000, 32'h0, 4'h0, 32'h0000_0120, RESP_OKAY);
    add_test("wr_status_ro", 1'b1, 12'h00C, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_OKAY);
    add_test("rd_status_ro", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0100, RESP_OKAY);
    add_test("push_1", 1'b1, 12'h010, 32'h1111_1111, 4'hF, 32'h0, RESP_OKAY);
    add_test("push_2", 1'b1, 12'h010, 32'h2222_2222, 4'hF, 32'h0, RESP_OKAY);
    add_test("push_3", 1'b1, 12'h010, 32'h3333_3333, 4'hF, 32'h0, RESP_OKAY);
    add_test("status_lvl3", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0003, RESP_OKAY);
    add_test("push_4", 1'b1, 12'h010, 32'h4444_4444, 4'hF, 32'h0, RESP_OKAY);
    add_test("status_full", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0204, RESP_OKAY);
    add_test("push_overflow", 1'b1, 12'h010, 32'h5555_5555, 4'hF, 32'h0, RESP_SLVERR);
    add_test("pop_1", 1'b0, 12'h010, 32'h0, 4'h0, 32'h1111_1111, RESP_OKAY);
    add_test("pop_2", 1'b0, 12'h010, 32'h0, 4'h0, 32'h2222_2222, RESP_OKAY);
    add_test("pop_3", 1'b0, 12'h010, 32'h0, 4'h0, 32'h3333_3333, RESP_OKAY);
    add_test("pop_4", 1'b0, 12'h010, 32'h0, 4'h0, 32'h4444_4444, RESP_OKAY);
    add_test("pop_underflow", 1'b0, 12'h010, 32'h0, 4'h0, 32'h0, RESP_SLVERR);
    add_test("status_empty", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0100, RESP_OKAY);
    add_test("rd_unmapped", 1'b0, 12'h014, 32'h0, 4'h0, 32'h0, RESP_SLVERR);
    add_test("wr_unmapped", 1'b1, 12'h014, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_SLVERR);
    add_test("rd_unaligned", 1'b0, 12'h006, 32'h0, 4'h0, 32'h0, RESP_SLVERR);
    add_test("wr_unaligned", 1'b1, 12'h00A, 32'hFFFF_FFFF, 4'hF, 32'h0, RESP_SLVERR);
    add_test("decode_scratch", 1'b0, 12'h008, 32'h0, 4'h0, 32'h12BB_56DD, RESP_OKAY);
    add_test("decode_control", 1'b0, 12'h004, 32'h0, 4'h0, 32'h8000_0000, RESP_OKAY);
    add_bad("rd_len3", 1'b0, 12'h008, 8'd3, 3'd2, 2'b01, 1'b0);
    add_bad("rd_size1", 1'b0, 12'h008, 8'd0, 3'd1, 2'b01, 1'b0);
    add_bad("rd_fixed", 1'b0, 12'h008, 8'd0, 3'd2, 2'b00, 1'b0);
    add_bad("rd_lock", 1'b0, 12'h008, 8'd0, 3'd2, 2'b01, 1'b1);
    add_bad("wr_len3", 1'b1, 12'h008, 8'd3, 3'd2, 2'b01, 1'b0);
    add_bad("wr_size1", 1'b1, 12'h008, 8'd0, 3'd1, 2'b01, 1'b0);
    add_bad("wr_fixed", 1'b1, 12'h008, 8'd0, 3'd2, 2'b00, 1'b0);
    add_bad("wr_lock", 1'b1, 12'h004, 8'd0, 3'd2, 2'b01, 1'b1);
    add_bad("push_len1", 1'b1, 12'h010, 8'd1, 3'd2, 2'b01, 1'b0);
    add_test("bad_scratch", 1'b0, 12'h008, 32'h0, 4'h0, 32'h12BB_56DD, RESP_OKAY);
    add_test("bad_control", 1'b0, 12'h004, 32'h0, 4'h0, 32'h8000_0000, RESP_OKAY);
    add_test("bad_status", 1'b0, 12'h00C, 32'h0, 4'h0, 32'h0000_0100, RESP_OKAY);
  endtask

  // Called and returns on a falling edge
  task automatic axi_read(input test_t t, input axi_id_t id, output csr_data_t data,
                          output axi_resp_t resp, output axi_id_t rid, output logic last);
    int        delay;
    csr_data_t held;
    araddr_i  = t.addr;
    arlen_i   = t.len;
    arsize_i  = t.size;
    arburst_i = t.burst;
    arlock_i  = t.lock;
    arid_i    = id;
    aruser_i  = $random(seed);
    arvalid_i = 1'b1;
    while (!arready_o) @(negedge clk_i);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    while (!rvalid_o) @(negedge clk_i);
    held  = rdata_o;
    delay = $random(seed) & 3;
    repeat (delay) begin
      @(negedge clk_i);
      check_value({t.name, " rvalid held"}, 32'h1, 32'(rvalid_o));
      check_value({t.name, " rdata held"}, held, rdata_o);
    end
    rready_i = 1'b1;
    data     = rdata_o;
    resp     = rresp_o;
    rid      = rid_o;
    last     = rlast_o;
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  task automatic axi_write(input test_t t, input axi_id_t id, output axi_resp_t resp,
                           output axi_id_t bid);
    int delay;
    awaddr_i  = t.addr;
    awlen_i   = t.len;
    awsize_i  = t.size;
    awburst_i = t.burst;
    awlock_i  = t.lock;
    awid_i    = id;
    awuser_i  = $random(seed);
    awvalid_i = 1'b1;
    wdata_i   = t.data;
    wstrb_i   = t.strb;
    wlast_i   = 1'b1;
    wvalid_i  = 1'b1;
    while (!(awready_o && wready_o)) @(negedge clk_i);
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) @(negedge clk_i);
    delay = $random(seed) & 3;
    repeat (delay) @(negedge clk_i);
    bready_i = 1'b1;
    resp     = bresp_o;
    bid      = bid_o;
    @(negedge clk_i);
    bready_i = 1'b0;
  endtask

  initial begin
    csr_data_t data;
    axi_resp_t resp;
    axi_id_t   id;
    axi_id_t   rsp_id;
    logic      last;
    seed      = 88377;
    rst_i     = 1'b1;
    araddr_i  = '0;
    arburst_i = 2'b01;
    arsize_i  = 3'd2;
    arlen_i   = 8'd0;
    aruser_i  = '0;
    arid_i    = '0;
    arlock_i  = 1'b0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    awaddr_i  = '0;
    awburst_i = 2'b01;
    awsize_i  = 3'd2;
    awlen_i   = 8'd0;
    awuser_i  = '0;
    awid_i    = '0;
    awlock_i  = 1'b0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = 4'h0;
    wlast_i   = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    build_table();
    cycle_limit = tests.size() * 40 + 100;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (tests[i]) begin
      id = axi_id_t'(i);
      if (tests[i].is_wr) begin
        axi_write(tests[i], id, resp, rsp_id);
        check_value({tests[i].name, " bresp"}, 32'(tests[i].exp_resp), 32'(resp));
        check_value({tests[i].name, " bid"}, 32'(id), 32'(rsp_id));
      end else begin
        axi_read(tests[i], id, data, resp, rsp_id, last);
        check_value({tests[i].name, " rdata"}, tests[i].exp_data, data);
        check_value({tests[i].name, " rresp"}, 32'(tests[i].exp_resp), 32'(resp));
        check_value({tests[i].name, " rid"}, 32'(id), 32'(rsp_id));
        check_value({tests[i].name, " rlast"}, 32'h1, 32'(last));
      end
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
i3c_csr_pkg.sv
csr_data_queue.sv
csr_regfile.sv
axi_adapter.sv
i3c_csr_axi_top.sv
i3c_csr_axi_checker.sv
i3c_csr_axi_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module i3c_csr_axi_tb -f filelist.f \
  && ./obj_dir/Vi3c_csr_axi_tb | tee /dev/stderr | grep -qxF ">>> PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
